/* design/game_config.sv */
`timescale 1ns/1ns
`include "game_settings.svh"

module game_config (
  input  logic                clk,
  input  logic                out_rst,
  input  game_pkg::phase_t    phase,
  input  game_pkg::key_hit_t  key_hit,
  output game_pkg::bcd2_t     time_field,
  output game_pkg::bcd2_t     goal_field,
  output logic                set_goal_mode
);

  localparam game_pkg::bcd2_t INIT_TIME = '{
    tens: 4'(`GAME_INIT_TIME / 10),
    ones: 4'(`GAME_INIT_TIME % 10)
  };
  localparam game_pkg::bcd2_t INIT_GOAL = '{
    tens: 4'(`GAME_INIT_GOAL / 10),
    ones: 4'(`GAME_INIT_GOAL % 10)
  };

  logic edit_en;

  // old ones digit moves up, new digit enters at ones
  function automatic game_pkg::bcd2_t shift_in(game_pkg::bcd2_t field, logic [3:0] d);
    game_pkg::bcd2_t res;
    res.tens = field.ones;
    res.ones = d;
    return res;
  endfunction

  assign edit_en = (phase == game_pkg::PH_SETUP) && key_hit.hit;

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      time_field    <= INIT_TIME;
      goal_field    <= INIT_GOAL;
      set_goal_mode <= 1'b0;
    end else if (phase == game_pkg::PH_IDLE) begin
      time_field    <= INIT_TIME;
      goal_field    <= INIT_GOAL;
      set_goal_mode <= 1'b0;  // back to the time field
    end else if (edit_en) begin
      if (key_hit.space) begin
        set_goal_mode <= ~set_goal_mode;
      end else if (set_goal_mode) begin
        goal_field <= shift_in(goal_field, key_hit.digit);
      end else begin
        time_field <= shift_in(time_field, key_hit.digit);
      end
    end
  end

  // fields hold their value through play and result, game_core
  // samples time_field only on the start pulse that enters play

endmodule

/* design/game_core.sv */
`timescale 1ns/1ns
`include "game_settings.svh"

module game_core (
  input  logic                  clk,
  input  logic                  out_rst,
  input  logic                  start,
  input  logic                  tick,
  input  game_pkg::key_hit_t    key_hit,
  input  game_pkg::bcd2_t       time_field,
  input  game_pkg::bcd2_t       goal_field,
  input  logic [15:0]           led,
  output game_pkg::phase_t      phase,
  output logic                  win,
  output logic                  play_step,
  output game_pkg::disp_word_t  disp
);

  localparam int HOLD_W = $clog2(`GAME_HOLD_TICKS + 1);

  localparam game_pkg::disp_word_t WIN_WORD =
    {game_pkg::G_W, game_pkg::G_I, game_pkg::G_N, game_pkg::G_BLANK};
  localparam game_pkg::disp_word_t LOSE_WORD =
    {game_pkg::G_L, 4'h0, game_pkg::G_S, game_pkg::G_BLANK};

  game_pkg::phase_t phase_nxt;
  game_pkg::bcd2_t  countdown;
  game_pkg::bcd2_t  hit_cnt;
  logic [HOLD_W-1:0] hold_cnt;
  logic             goal_met;
  logic             time_up;
  logic             hold_done;
  logic [3:0]       led_idx;
  logic             score;

  function automatic game_pkg::bcd2_t bcd_dec(game_pkg::bcd2_t v);
    game_pkg::bcd2_t r;
    r = v;
    if (v.ones == 4'd0) begin
      r.ones = 4'd9;
      r.tens = v.tens - 4'd1;
    end else begin
      r.ones = v.ones - 4'd1;
    end
    return r;
  endfunction

  function automatic game_pkg::bcd2_t bcd_inc(game_pkg::bcd2_t v);
    game_pkg::bcd2_t r;
    r = v;
    if (v.ones == 4'd9) begin
      r.ones = 4'd0;
      r.tens = (v.tens == 4'd9) ? 4'd0 : v.tens + 4'd1;
    end else begin
      r.ones = v.ones + 4'd1;
    end
    return r;
  endfunction

  assign goal_met  = (hit_cnt == goal_field);
  assign time_up   = (countdown == '0);
  assign hold_done = tick && (hold_cnt == HOLD_W'(`GAME_HOLD_TICKS - 1));
  assign play_step = tick && (phase == game_pkg::PH_PLAY);

  // key k lights up led 16-k, only keys 1..9 land on the board
  assign led_idx = 4'(5'd16 - {1'b0, key_hit.digit});
  assign score   = key_hit.hit && !key_hit.space && (key_hit.digit != 4'd0)
                   && led[led_idx];

  always_comb begin
    phase_nxt = phase;
    case (phase)
      game_pkg::PH_IDLE:   if (start) phase_nxt = game_pkg::PH_SETUP;
      game_pkg::PH_SETUP:  if (start) phase_nxt = game_pkg::PH_PLAY;
      game_pkg::PH_PLAY:   if (goal_met || time_up) phase_nxt = game_pkg::PH_RESULT;
      game_pkg::PH_RESULT: if (hold_done) phase_nxt = game_pkg::PH_IDLE;
      default:             phase_nxt = game_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      phase     <= game_pkg::PH_IDLE;
      countdown <= '0;
      hit_cnt   <= '0;
      hold_cnt  <= '0;
      win       <= 1'b0;
    end else begin
      phase <= phase_nxt;
      if (phase == game_pkg::PH_SETUP && start) begin
        countdown <= time_field;
        hit_cnt   <= '0;
      end else if (phase == game_pkg::PH_PLAY) begin
        if (tick && !time_up) countdown <= bcd_dec(countdown);
        if (score) hit_cnt <= bcd_inc(hit_cnt);
        if (goal_met || time_up) win <= goal_met;  // goal beats timeout
      end
      if (phase == game_pkg::PH_RESULT) begin
        if (tick) hold_cnt <= hold_cnt + 1'b1;
      end else begin
        hold_cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      disp <= 16'hFFFF;
    end else begin
      case (phase)
        game_pkg::PH_SETUP:  disp <= {time_field, goal_field};
        game_pkg::PH_PLAY:   disp <= {countdown, hit_cnt};
        game_pkg::PH_RESULT: disp <= win ? WIN_WORD : LOSE_WORD;
        default:             disp <= 16'hFFFF;  // all blank
      endcase
    end
  end

endmodule

/* design/game_pkg.sv */
package game_pkg;

  typedef enum logic [1:0] {
    PH_IDLE   = 2'd0,
    PH_SETUP  = 2'd1,
    PH_PLAY   = 2'd2,
    PH_RESULT = 2'd3
  } phase_t;

  typedef struct packed {
    logic       valid;
    logic       make;  // 0 = release
    logic [8:0] code;  // bit 8 set for extended codes
  } key_event_t;

  typedef struct packed {
    logic       hit;
    logic       space;
    logic [3:0] digit;
  } key_hit_t;

  typedef struct packed {
    logic [3:0] tens;
    logic [3:0] ones;
  } bcd2_t;

  // four glyph codes, leftmost digit in [15:12]
  typedef logic [15:0] disp_word_t;

  // letter glyphs above the numerals
  typedef enum logic [3:0] {
    G_W     = 4'hA,
    G_I     = 4'hB,
    G_N     = 4'hC,
    G_L     = 4'hD,
    G_S     = 4'hE,
    G_BLANK = 4'hF
  } glyph_t;

endpackage

/* design/game_settings.svh */
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// values restored in idle, plain decimal
`define GAME_INIT_TIME 30
`define GAME_INIT_GOAL 10

// result phase length in ticks
`define GAME_HOLD_TICKS 4

`define GAME_LFSR_SEED 9'h160

// scan advances every 2**SEG_REFRESH_BITS cycles
`define SEG_REFRESH_BITS 4

// led patterns per phase
`define LED_IDLE 16'h8001
`define LED_SET_TIME 16'hFF01
`define LED_SET_GOAL 16'h80FF

`endif

/* design/key_decoder.sv */
`timescale 1ns/1ns

module key_decoder (
  input  logic                  clk,
  input  logic                  out_rst,
  input  game_pkg::key_event_t  key_in,
  output game_pkg::key_hit_t    key_hit
);

  logic [20:0] held;  // one flag per known key
  logic [4:0]  key_idx;
  logic        key_known;
  logic [3:0]  key_digit;
  logic        hit_q;
  logic        space_q;
  logic [3:0]  digit_q;

  always_comb begin
    key_idx   = 5'd0;
    key_known = 1'b1;
    case (key_in.code[7:0])
      8'h45: key_idx = 5'd0;
      8'h16: key_idx = 5'd1;
      8'h1E: key_idx = 5'd2;
      8'h26: key_idx = 5'd3;
      8'h25: key_idx = 5'd4;
      8'h2E: key_idx = 5'd5;
      8'h36: key_idx = 5'd6;
      8'h3D: key_idx = 5'd7;
      8'h3E: key_idx = 5'd8;
      8'h46: key_idx = 5'd9;
      8'h70: key_idx = 5'd10;  // keypad row
      8'h69: key_idx = 5'd11;
      8'h72: key_idx = 5'd12;
      8'h7A: key_idx = 5'd13;
      8'h6B: key_idx = 5'd14;
      8'h73: key_idx = 5'd15;
      8'h74: key_idx = 5'd16;
      8'h6C: key_idx = 5'd17;
      8'h75: key_idx = 5'd18;
      8'h7D: key_idx = 5'd19;
      8'h29: key_idx = 5'd20;  // space
      default: key_known = 1'b0;
    endcase
    // only keypad digits may carry the extended flag
    if (key_in.code[8] && (key_idx < 5'd10 || key_idx == 5'd20)) begin
      key_known = 1'b0;
    end
    key_digit = (key_idx >= 5'd10) ? 4'(key_idx - 5'd10) : key_idx[3:0];
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      held  <= '0;
      hit_q <= 1'b0;
    end else begin
      hit_q <= key_in.valid && key_in.make && key_known && !held[key_idx];
      if (key_in.valid && key_known) begin
        held[key_idx] <= key_in.make;
      end
    end
  end

  always_ff @(posedge clk) begin
    space_q <= (key_idx == 5'd20);
    digit_q <= (key_idx == 5'd20) ? 4'd0 : key_digit;
  end

  assign key_hit = '{hit: hit_q, space: space_q, digit: digit_q};

endmodule

/* design/led_pattern.sv */
`timescale 1ns/1ns
`include "game_settings.svh"

module led_pattern (
  input  logic              clk,
  input  logic              out_rst,
  input  game_pkg::phase_t  phase,
  input  logic              set_goal_mode,
  input  logic              play_step,
  input  logic              tick,
  output logic [15:0]       led
);

  logic [8:0]       lfsr;
  logic [8:0]       lfsr_nxt;
  game_pkg::phase_t phase_q;
  logic             result_entry;

  // galois shift right, bit 0 wraps to bit 8 and taps 6, 5, 3
  function automatic logic [8:0] lfsr_step(logic [8:0] s);
    return {s[0], s[8:1]} ^ (s[0] ? 9'b0_0110_1000 : 9'b0);
  endfunction

  assign lfsr_nxt     = play_step ? lfsr_step(lfsr) : lfsr;
  assign result_entry = (phase == game_pkg::PH_RESULT) && (phase_q != game_pkg::PH_RESULT);

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      lfsr    <= `GAME_LFSR_SEED;
      phase_q <= game_pkg::PH_IDLE;
    end else begin
      phase_q <= phase;
      lfsr    <= (phase == game_pkg::PH_PLAY) ? lfsr_nxt : `GAME_LFSR_SEED;
    end
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      led <= '0;
    end else begin
      case (phase)
        game_pkg::PH_IDLE:  led <= `LED_IDLE;
        game_pkg::PH_SETUP: led <= set_goal_mode ? `LED_SET_GOAL : `LED_SET_TIME;
        game_pkg::PH_PLAY:  led <= {lfsr_nxt, 7'b0000011};
        default: begin
          if (result_entry) begin
            led <= 16'hFFFF;
          end else if (tick) begin
            led <= ~led;  // flash
          end
        end
      endcase
    end
  end

endmodule

/* design/seg_scan.sv */
`timescale 1ns/1ns
`include "game_settings.svh"

module seg_scan (
  input  logic                  clk,
  input  logic                  out_rst,
  input  game_pkg::disp_word_t  disp,
  output logic [3:0]            digit,
  output logic [6:0]            display
);

  localparam int CNT_W = `SEG_REFRESH_BITS + 2;

  logic [CNT_W-1:0] refresh_cnt;
  logic [1:0]       sel;
  logic [3:0]       glyph;
  logic [6:0]       seg;

  assign sel   = refresh_cnt[CNT_W-1 -: 2];
  assign glyph = disp[sel*4 +: 4];  // sel 3 is the leftmost digit

  // active low, gfedcba
  always_comb begin
    case (glyph)
      4'h0:              seg = 7'b1000000;
      4'h1:              seg = 7'b1111001;
      4'h2:              seg = 7'b0100100;
      4'h3:              seg = 7'b0110000;
      4'h4:              seg = 7'b0011001;
      4'h5:              seg = 7'b0010010;
      4'h6:              seg = 7'b0000010;
      4'h7:              seg = 7'b1111000;
      4'h8:              seg = 7'b0000000;
      4'h9:              seg = 7'b0010000;
      game_pkg::G_W:     seg = 7'b1000001;  // drawn as U
      game_pkg::G_I:     seg = 7'b1111001;
      game_pkg::G_N:     seg = 7'b0101011;  // lower case n
      game_pkg::G_L:     seg = 7'b1000111;
      game_pkg::G_S:     seg = 7'b0010010;
      default:           seg = 7'b1111111;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      refresh_cnt <= '0;
      digit       <= 4'b1111;
      display     <= 7'b1111111;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
      digit       <= ~(4'b0001 << sel);
      display     <= seg;
    end
  end

endmodule

/* design/whack_top.sv */
`timescale 1ns/1ns

module whack_top (
  input  logic                  clk,
  input  logic                  out_rst,
  input  logic                  start,
  input  logic                  tick,
  input  game_pkg::key_event_t  key_in,
  output logic [15:0]           led,
  output logic [3:0]            digit,
  output logic [6:0]            display
);

  game_pkg::key_hit_t   key_hit;
  game_pkg::phase_t     phase;
  game_pkg::bcd2_t      time_field;
  game_pkg::bcd2_t      goal_field;
  game_pkg::disp_word_t disp;
  logic                 set_goal_mode;
  logic                 play_step;

  key_decoder i_key_decoder (
    .clk     (clk),
    .out_rst (out_rst),
    .key_in  (key_in),
    .key_hit (key_hit)
  );

  game_config i_game_config (
    .clk           (clk),
    .out_rst       (out_rst),
    .phase         (phase),
    .key_hit       (key_hit),
    .time_field    (time_field),
    .goal_field    (goal_field),
    .set_goal_mode (set_goal_mode)
  );

  // win only steers the result glyphs inside game_core
  game_core i_game_core (
    .clk        (clk),
    .out_rst    (out_rst),
    .start      (start),
    .tick       (tick),
    .key_hit    (key_hit),
    .time_field (time_field),
    .goal_field (goal_field),
    .led        (led),
    .phase      (phase),
    .win        (),
    .play_step  (play_step),
    .disp       (disp)
  );

  led_pattern i_led_pattern (
    .clk           (clk),
    .out_rst       (out_rst),
    .phase         (phase),
    .set_goal_mode (set_goal_mode),
    .play_step     (play_step),
    .tick          (tick),
    .led           (led)
  );

  seg_scan i_seg_scan (
    .clk     (clk),
    .out_rst (out_rst),
    .disp    (disp),
    .digit   (digit),
    .display (display)
  );

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ns
`include "game_settings.svh"

module tb_top;

  localparam int TICK_GAP = 40;
  localparam int ROUNDS = 2;
  localparam int RESET_CYC = 8;
  localparam int IDLE_CYC = 70;  // one full scan of the blank display
  localparam int PRESS_CYC = 14;  // worst press incl. gaps
  localparam int ROUND_CYC = 24 * PRESS_CYC + 6 * TICK_GAP + 5 * TICK_GAP + 20;
  localparam int LIMIT = (RESET_CYC + IDLE_CYC + ROUNDS * ROUND_CYC) * 12 / 10;

  logic                 clk;
  logic                 out_rst;
  logic                 start;
  logic                 tick;
  game_pkg::key_event_t key_in;
  logic [15:0]          led;
  logic [3:0]           digit;
  logic [6:0]           display;

  integer seed;
  int     cycles;
  int     tick_cnt;

  // reference model state
  game_pkg::phase_t m_phase;
  game_pkg::phase_t m_phase_q;
  logic [20:0] m_held;
  logic        m_hit;
  logic        m_space;
  logic [3:0]  m_digit;
  logic [7:0]  m_time;
  logic [7:0]  m_goal;
  logic        m_sel;
  int          m_cd;
  int          m_cnt;
  int          m_hold;
  logic        m_win;
  logic [8:0]  m_lfsr;
  logic [15:0] m_led;
  logic [15:0] m_disp;
  logic [15:0] m_shown;  // word the scan is currently drawing
  logic        seen_win;
  logic        seen_lose;

  logic [15:0] got_word;
  logic [15:0] exp_word;
  logic [3:0]  slot_mask;

  whack_top i_whack_top (
    .clk     (clk),
    .out_rst (out_rst),
    .start   (start),
    .tick    (tick),
    .key_in  (key_in),
    .led     (led),
    .digit   (digit),
    .display (display)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run("value mismatch");
    end
  endtask

  function automatic int key_index(logic [8:0] code);
    int i;
    case (code[7:0])
      8'h45: i = 0;
      8'h16: i = 1;
      8'h1E: i = 2;
      8'h26: i = 3;
      8'h25: i = 4;
      8'h2E: i = 5;
      8'h36: i = 6;
      8'h3D: i = 7;
      8'h3E: i = 8;
      8'h46: i = 9;
      8'h70: i = 10;
      8'h69: i = 11;
      8'h72: i = 12;
      8'h7A: i = 13;
      8'h6B: i = 14;
      8'h73: i = 15;
      8'h74: i = 16;
      8'h6C: i = 17;
      8'h75: i = 18;
      8'h7D: i = 19;
      8'h29: i = 20;
      default: i = -1;
    endcase
    if (code[8] && (i < 10 || i == 20)) i = -1;  // extended only on keypad
    return i;
  endfunction

  function automatic logic [8:0] digit_code(int d, bit keypad);
    logic [7:0] main_row [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
                                  8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
    logic [7:0] pad_row [10] = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B,
                                 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D};
    return keypad ? {1'b1, pad_row[d]} : {1'b0, main_row[d]};
  endfunction

  function automatic logic [8:0] lfsr_next(logic [8:0] s);
    logic [8:0] r;
    r = s >> 1;
    r[8] = s[0];
    if (s[0]) begin
      r[6] = ~r[6];
      r[5] = ~r[5];
      r[3] = ~r[3];
    end
    return r;
  endfunction

  function automatic logic [7:0] to_bcd(int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  function automatic int from_bcd(logic [7:0] b);
    return b[7:4] * 10 + b[3:0];
  endfunction

  // 5'h1F marks a pattern not in the table
  function automatic logic [4:0] seg_to_glyph(logic [6:0] s);
    case (s)
      7'b1000000: return 5'h0;
      7'b1111001: return 5'h1;
      7'b0100100: return 5'h2;
      7'b0110000: return 5'h3;
      7'b0011001: return 5'h4;
      7'b0010010: return 5'h5;
      7'b0000010: return 5'h6;
      7'b1111000: return 5'h7;
      7'b0000000: return 5'h8;
      7'b0010000: return 5'h9;
      7'b1000001: return 5'hA;  // W as U
      7'b0101011: return 5'hC;
      7'b1000111: return 5'hD;
      7'b1111111: return 5'hF;
      default:    return 5'h1F;
    endcase
  endfunction

  task automatic model_reset;
    m_phase = game_pkg::PH_IDLE;
    m_phase_q = game_pkg::PH_IDLE;
    m_held = '0;
    m_hit = 1'b0;
    m_space = 1'b0;
    m_digit = 4'd0;
    m_time = to_bcd(`GAME_INIT_TIME);
    m_goal = to_bcd(`GAME_INIT_GOAL);
    m_sel = 1'b0;
    m_cd = 0;
    m_cnt = 0;
    m_hold = 0;
    m_win = 1'b0;
    m_lfsr = `GAME_LFSR_SEED;
    m_led = 16'h0;
    m_disp = 16'hFFFF;
    m_shown = 16'hFFFF;
  endtask

  task automatic model_step;
    game_pkg::phase_t np;
    logic [15:0] led_old;
    logic [8:0]  lnext;
    logic        goal_met;
    logic        time_up;
    logic        score;
    int          idx;
    led_old = m_led;
    np = m_phase;
    m_shown = m_disp;
    case (m_phase)
      game_pkg::PH_SETUP:  m_disp = {m_time, m_goal};
      game_pkg::PH_PLAY:   m_disp = {to_bcd(m_cd), to_bcd(m_cnt)};
      game_pkg::PH_RESULT: m_disp = m_win ? 16'hABCF : 16'hD0EF;
      default:             m_disp = 16'hFFFF;
    endcase
    // core
    goal_met = (m_cnt == from_bcd(m_goal));
    time_up = (m_cd == 0);
    score = m_hit && !m_space && m_digit != 0 && led_old[16 - m_digit];
    case (m_phase)
      game_pkg::PH_IDLE:  if (start) np = game_pkg::PH_SETUP;
      game_pkg::PH_SETUP: if (start) np = game_pkg::PH_PLAY;
      game_pkg::PH_PLAY:  if (goal_met || time_up) np = game_pkg::PH_RESULT;
      default: if (tick && m_hold == `GAME_HOLD_TICKS - 1) np = game_pkg::PH_IDLE;
    endcase
    if (m_phase == game_pkg::PH_SETUP && start) begin
      m_cd = from_bcd(m_time);
      m_cnt = 0;
    end else if (m_phase == game_pkg::PH_PLAY) begin
      if (tick && !time_up) m_cd = m_cd - 1;
      if (score) m_cnt = (m_cnt + 1) % 100;
      if (goal_met || time_up) begin
        m_win = goal_met;
        if (goal_met) seen_win = 1'b1;
        else seen_lose = 1'b1;
      end
    end
    if (m_phase == game_pkg::PH_RESULT) begin
      if (tick) m_hold = m_hold + 1;
    end else begin
      m_hold = 0;
    end
    // leds, before the field select moves
    lnext = (tick && m_phase == game_pkg::PH_PLAY) ? lfsr_next(m_lfsr) : m_lfsr;
    case (m_phase)
      game_pkg::PH_IDLE:  m_led = `LED_IDLE;
      game_pkg::PH_SETUP: m_led = m_sel ? `LED_SET_GOAL : `LED_SET_TIME;
      game_pkg::PH_PLAY:  m_led = {lnext, 7'b0000011};
      default: begin
        if (m_phase_q != game_pkg::PH_RESULT) m_led = 16'hFFFF;
        else if (tick) m_led = ~m_led;
      end
    endcase
    m_lfsr = (m_phase == game_pkg::PH_PLAY) ? lnext : `GAME_LFSR_SEED;
    m_phase_q = m_phase;
    // config fields
    if (m_phase == game_pkg::PH_IDLE) begin
      m_time = to_bcd(`GAME_INIT_TIME);
      m_goal = to_bcd(`GAME_INIT_GOAL);
      m_sel = 1'b0;
    end else if (m_phase == game_pkg::PH_SETUP && m_hit) begin
      if (m_space) m_sel = ~m_sel;
      else if (m_sel) m_goal = {m_goal[3:0], m_digit};
      else m_time = {m_time[3:0], m_digit};
    end
    // decoder
    idx = key_index(key_in.code);
    m_hit = 1'b0;
    if (key_in.valid && idx >= 0) begin
      m_hit = key_in.make && !m_held[idx];
      m_held[idx] = key_in.make;
      m_space = (idx == 20);
      m_digit = (idx == 20) ? 4'd0 : 4'(idx % 10);
    end
    m_phase = np;
  endtask

  always @(posedge clk or posedge out_rst) begin
    if (out_rst) model_reset();
    else model_step();
  end

  always @(posedge clk) begin
    logic rst_at_edge;
    rst_at_edge = out_rst;
    #2;
    if (rst_at_edge) begin
      tick_cnt = 0;
      tick = 1'b0;
    end else begin
      tick_cnt = tick_cnt + 1;
      tick = (tick_cnt % TICK_GAP == 0);
    end
    cycles = cycles + 1;
    if (cycles > LIMIT) abort_run("timeout, the game did not finish in time");
  end

  always @(negedge clk) begin
    int slot;
    logic [4:0] g;
    logic [3:0] e;
    if (!out_rst) begin
      check("led", m_led, led);
      if (digit != 4'hF) begin
        case (digit)
          4'b1110: slot = 0;
          4'b1101: slot = 1;
          4'b1011: slot = 2;
          4'b0111: slot = 3;
          default: abort_run("digit select is not one-hot");
        endcase
        g = seg_to_glyph(display);
        if (g == 5'h1F) abort_run("display shows a pattern outside the glyph table");
        e = m_shown[slot*4 +: 4];
        if (e == 4'hB) e = 4'h1;  // I drawn like 1
        if (e == 4'hE) e = 4'h5;  // S drawn like 5
        got_word[slot*4 +: 4] = g[3:0];
        exp_word[slot*4 +: 4] = e;
        slot_mask[slot] = 1'b1;
        if (slot_mask == 4'hF) begin
          check("display", exp_word, got_word);
          slot_mask = 4'h0;
        end
      end
    end
  end

  task automatic send_key(input logic [8:0] code, input logic make);
    @(posedge clk);
    #2;
    key_in = '{valid: 1'b1, make: make, code: code};
    @(posedge clk);
    #2;
    key_in = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic press_key(input logic [8:0] code);
    send_key(code, 1'b1);
    if ($unsigned($random(seed)) % 4 == 0) send_key(code, 1'b1);  // autorepeat
    idle_cycles($unsigned($random(seed)) % 4);
    send_key(code, 1'b0);
    idle_cycles($unsigned($random(seed)) % 4);
  endtask

  task automatic pulse_start;
    @(posedge clk);
    #2;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic random_setup(input int n);
    int r;
    repeat (n) begin
      r = $unsigned($random(seed)) % 8;
      case (r)
        0: press_key(9'h029);
        1: press_key(9'h01C);  // letter key, not mapped
        2: press_key(9'h145);  // extended main-row code
        default: press_key(digit_code($unsigned($random(seed)) % 10, r[0]));
      endcase
    end
  endtask

  task automatic set_field(input logic goal_sel, input int v);
    if (m_sel != goal_sel) press_key(9'h029);
    press_key(digit_code(v / 10, 1'b0));
    press_key(digit_code(v % 10, 1'b1));
  endtask

  task automatic play_round(input int t, input int g);
    pulse_start();
    random_setup(12);
    set_field(1'b0, t);
    set_field(1'b1, g);
    pulse_start();
    while (m_phase == game_pkg::PH_PLAY) begin
      press_key(digit_code(1 + $unsigned($random(seed)) % 9, $random(seed) & 1));
    end
    while (m_phase != game_pkg::PH_IDLE) begin
      @(posedge clk);
      #2;
    end
    idle_cycles(4);
  endtask

  initial begin
    seed = 32'h0664_0246;
    cycles = 0;
    tick_cnt = 0;
    seen_win = 1'b0;
    seen_lose = 1'b0;
    slot_mask = 4'h0;
    got_word = '0;
    exp_word = '0;
    start = 1'b0;
    tick = 1'b0;
    key_in = '0;
    out_rst = 1'b1;
    repeat (RESET_CYC) @(posedge clk);
    #2;
    out_rst = 1'b0;
    idle_cycles(IDLE_CYC);
    play_round(5, 2);
    play_round(2, 99);
    if (!seen_win) begin
      abort_run("no round ended with a win");
    end else if (!seen_lose) begin
      abort_run("no round ended with a loss");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/bash
# builds the testbench with Verilator, runs it and searches the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_top \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation returned an error status"

if [ ! -f sim.log ] || grep -q "Some tests failed" sim.log; then
  echo "FAIL, see build.log and sim.log"
  exit 1
fi
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL, no pass line"; exit 1; }

/* tb.f */
+incdir+design
design/game_pkg.sv
design/key_decoder.sv
design/game_config.sv
design/game_core.sv
design/led_pattern.sv
design/seg_scan.sv
design/whack_top.sv
dv/tb_top.sv
